/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -Wno-fatal -j 0
TOP := tb_adxl_apb
FILELIST := adxl_apb.f
OBJ_DIR := obj_dir

SIM := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	$(SIM) | tee /dev/stderr | grep -q '^test passed$$'

clean:
	rm -rf $(OBJ_DIR)

/* adxl_apb.f */
src/i2c_pkg.sv
src/adxl_pkg.sv
src/apb_regs.sv
src/xfer_sequencer.sv
src/i2c_byte_engine.sv
src/sample_unpack.sv
src/adxl_apb_top.sv
bench/tb_clock.sv
bench/adxl_sensor_model.sv
bench/tb_adxl_apb.sv

/* bench/adxl_sensor_model.sv */
`timescale 1ns/1ps

module adxl_sensor_model (
	input  logic i_clk,
	input  logic i_scl_low,
	input  logic i_sda_low,
	input  logic i_absent,
	output logic o_sda
);
	localparam logic [6:0] SENSOR_ADDR = 7'h1D;
	localparam logic [31:0] FILL_SEED = 32'h03c2c942;

	logic [7:0] mem [256];
	logic scl;
	logic drive_low;
	logic scl_prev;
	logic sda_prev;
	logic active;
	logic tx;
	logic clocked;
	logic ack_mine;
	logic master_nack;
	logic [7:0] shreg;
	logic [7:0] txbyte;
	logic [7:0] ptr;
	int bit_cnt;
	int byte_idx;
	integer seed;

	// wired-and of both open-drain drivers
	assign scl = ~i_scl_low;
	assign o_sda = ~(i_sda_low | drive_low);

	initial begin
		seed = FILL_SEED;
		for (int i = 0; i < 256; i++)
			mem[i] = 8'($random(seed));
		drive_low = 1'b0;
		scl_prev = 1'b1;
		sda_prev = 1'b1;
		active = 1'b0;
		tx = 1'b0;
		clocked = 1'b0;
		ack_mine = 1'b0;
		master_nack = 1'b0;
		shreg = 8'h00;
		txbyte = 8'h00;
		ptr = 8'h00;
		bit_cnt = 0;
		byte_idx = 0;
	end

	task ack_byte();
		drive_low = 1'b1;
		ack_mine = 1'b1;
	endtask

	// first byte is the address, second the register pointer, then data
	task take_byte();
		if (byte_idx == 0) begin
			if (!i_absent && shreg[7:1] == SENSOR_ADDR) begin
				tx = shreg[0];
				ack_byte();
			end else begin
				active = 1'b0;
			end
		end else if (byte_idx == 1) begin
			ptr = shreg;
			ack_byte();
		end else begin
			mem[ptr] = shreg;
			ptr = ptr + 8'd1;
			ack_byte();
		end
		byte_idx++;
	endtask

	// runs on each falling scl after a clocked bit
	task end_bit();
		if (bit_cnt < 7) begin
			bit_cnt++;
			if (tx)
				drive_low = !txbyte[7 - bit_cnt];
		end else if (bit_cnt == 7) begin
			bit_cnt = 8;
			if (tx)
				drive_low = 1'b0;
			else
				take_byte();
		end else begin
			bit_cnt = 0;
			if (tx && (ack_mine || !master_nack)) begin
				txbyte = mem[ptr];
				ptr = ptr + 8'd1;
				drive_low = !txbyte[7];
			end else begin
				drive_low = 1'b0;
				if (tx)
					active = 1'b0;
			end
			ack_mine = 1'b0;
		end
	endtask

	// oversample both lines away from the DUT clock edge
	always @(negedge i_clk) begin
		logic scl_now;
		logic sda_now;
		scl_now = scl;
		sda_now = o_sda;
		if (scl_prev && scl_now && sda_prev && !sda_now) begin
			active = 1'b1;
			tx = 1'b0;
			byte_idx = 0;
			bit_cnt = 0;
			clocked = 1'b0;
			ack_mine = 1'b0;
			drive_low = 1'b0;
		end else if (scl_prev && scl_now && !sda_prev && sda_now) begin
			active = 1'b0;
			drive_low = 1'b0;
		end else if (active && !scl_prev && scl_now) begin
			clocked = 1'b1;
			if (bit_cnt < 8) begin
				if (!tx)
					shreg = {shreg[6:0], sda_now};
			end else if (tx) begin
				master_nack = sda_now;
			end
		end else if (active && scl_prev && !scl_now && clocked) begin
			clocked = 1'b0;
			end_bit();
		end
		scl_prev = scl_now;
		sda_prev = sda_now;
	end

endmodule

/* bench/tb_adxl_apb.sv */
`timescale 1ns/1ps

module tb_adxl_apb;
	import i2c_pkg::*;
	import adxl_pkg::*;

	localparam int CLK_NS = 4;
	// start, stop or one bit on the bus
	localparam int UNIT_CYCLES = 16;
	localparam int BYTE_CYCLES = 9 * UNIT_CYCLES;
	// pointer write plus an 11-byte read
	localparam int BURST_CYCLES = 4 * UNIT_CYCLES + 14 * BYTE_CYCLES;
	localparam int NUM_RAND = 8;
	localparam int NUM_TXN = 2 * NUM_RAND + 8;
	// twice the bus time leaves room for APB polling
	localparam int LIMIT_NS = NUM_TXN * BURST_CYCLES * CLK_NS * 2;

	logic clk;
	logic rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	apb_addr_t paddr;
	logic [31:0] pwdata;
	logic drdy;
	logic sda;
	logic absent;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic scl_low;
	logic sda_low;

	byte_t exp_mem [256];
	logic touched [256];
	integer seed;

	tb_clock u_clock (
		.o_clk(clk),
		.o_rst_n(rst_n)
	);

	adxl_apb_top adxl_apb_top_inst (
		.i_clk(clk), .i_rst_n(rst_n),
		.i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
		.i_paddr(paddr), .i_pwdata(pwdata),
		.i_drdy(drdy), .i_sda(sda),
		.o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr),
		.o_scl_low(scl_low), .o_sda_low(sda_low)
	);

	adxl_sensor_model u_sensor (
		.i_clk(clk),
		.i_scl_low(scl_low),
		.i_sda_low(sda_low),
		.i_absent(absent),
		.o_sda(sda)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_flag(input string name, input logic exp, input logic got);
		if (got !== exp)
			abort_run($sformatf("Error at %0t: %s expected %b got %b", $time, name, exp, got));
	endtask

	task automatic check_byte(input string name, input byte_t exp, input byte_t got);
		if (got !== exp)
			abort_run($sformatf("Error at %0t: %s expected %h got %h", $time, name, exp, got));
	endtask

	task automatic check_temp(input string name, input temp_t exp, input temp_t got);
		if (got !== exp)
			abort_run($sformatf("Error at %0t: %s expected %h got %h", $time, name, exp, got));
	endtask

	task automatic check_accel(input string name, input accel_t exp, input accel_t got);
		if (got !== exp)
			abort_run($sformatf("Error at %0t: %s expected %h got %h", $time, name, exp, got));
	endtask

	function automatic logic offset_mapped(input apb_addr_t addr);
		case (addr)
			OFS_CTRL, OFS_REG_ADDR, OFS_WR_DATA, OFS_STATUS, OFS_RD_DATA,
			OFS_TEMP, OFS_ACCX, OFS_ACCY, OFS_ACCZ: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// 12-bit temperature zero extended
	function automatic temp_t expect_temp();
		temp_t t;
		t = '0;
		t[11:0] = {exp_mem[REG_TEMP2][3:0], exp_mem[REG_TEMP2 + 8'd1]};
		return t;
	endfunction

	// 20-bit two's complement axis from three registers
	function automatic accel_t expect_axis(input reg_addr_t base);
		logic [19:0] raw;
		int val;
		raw = {exp_mem[base], exp_mem[base + 8'd1], exp_mem[base + 8'd2][7:4]};
		val = int'(raw);
		if (raw[19])
			val = val - (1 << 20);
		return accel_t'(val);
	endfunction

	task automatic apb_write(input apb_addr_t addr, input logic [31:0] data);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		check_flag("pready", 1'b1, pready);
		check_flag($sformatf("pslverr at offset %02h", addr), !offset_mapped(addr), pslverr);
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t addr, output logic [31:0] data);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		check_flag("pready", 1'b1, pready);
		check_flag($sformatf("pslverr at offset %02h", addr), !offset_mapped(addr), pslverr);
		data = prdata;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic wait_status(input int bit_pos, input logic level);
		logic [31:0] st;
		do
			apb_read(OFS_STATUS, st);
		while (st[bit_pos] !== level);
	endtask

	task automatic wait_idle();
		wait_status(0, 1'b0);
	endtask

	task automatic issue_write(input reg_addr_t addr, input byte_t data, input logic auto_on);
		apb_write(OFS_REG_ADDR, {24'b0, addr});
		apb_write(OFS_WR_DATA, {24'b0, data});
		apb_write(OFS_CTRL, {29'b0, auto_on, 2'b01});
		if (!absent)
			exp_mem[addr] = data;
	endtask

	task automatic issue_read(input reg_addr_t addr, input logic auto_on);
		apb_write(OFS_REG_ADDR, {24'b0, addr});
		apb_write(OFS_CTRL, {29'b0, auto_on, 2'b11});
	endtask

	task automatic check_reg_read(input reg_addr_t addr);
		logic [31:0] d;
		issue_read(addr, 1'b0);
		wait_idle();
		apb_read(OFS_RD_DATA, d);
		check_byte($sformatf("RD_DATA for register %02h", addr), exp_mem[addr], d[7:0]);
	endtask

	task automatic pulse_drdy();
		@(posedge clk);
		drdy <= 1'b1;
		repeat (4) @(posedge clk);
		drdy <= 1'b0;
	endtask

	// TEMP goes last since reading it clears sample valid
	task automatic check_sample();
		logic [31:0] d;
		apb_read(OFS_ACCX, d);
		check_accel("ACCX", expect_axis(REG_TEMP2 + 8'd2), accel_t'(d));
		apb_read(OFS_ACCY, d);
		check_accel("ACCY", expect_axis(REG_TEMP2 + 8'd5), accel_t'(d));
		apb_read(OFS_ACCZ, d);
		check_accel("ACCZ", expect_axis(REG_TEMP2 + 8'd8), accel_t'(d));
		apb_read(OFS_TEMP, d);
		check_temp("TEMP", expect_temp(), d);
		apb_read(OFS_STATUS, d);
		check_flag("STATUS sample valid after TEMP read", 1'b0, d[2]);
	endtask

	initial begin
		#(LIMIT_NS);
		abort_run($sformatf("timeout: the run did not finish within %0d ns", LIMIT_NS));
	end

	initial begin
		logic [31:0] d;
		reg_addr_t a;
		byte_t v;
		reg_addr_t addrs [NUM_RAND];
		int k;

		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		drdy = 1'b0;
		absent = 1'b0;
		// same seed and order as the sensor's own fill
		seed = 32'h03c2c942;
		for (int i = 0; i < 256; i++) begin
			exp_mem[i] = 8'($random(seed));
			touched[i] = 1'b0;
		end
		wait (rst_n === 1'b1);
		repeat (2) @(posedge clk);

		apb_read(OFS_STATUS, d);
		check_flag("STATUS busy after reset", 1'b0, d[0]);
		check_flag("STATUS nack after reset", 1'b0, d[1]);
		check_flag("STATUS sample valid after reset", 1'b0, d[2]);
		@(negedge clk);
		check_flag("scl_low after reset", 1'b0, scl_low);
		check_flag("sda_low after reset", 1'b0, sda_low);

		// random writes, then read every address back
		for (int n = 0; n < NUM_RAND; n++) begin
			a = 8'($random(seed));
			v = 8'($random(seed));
			addrs[n] = a;
			touched[a] = 1'b1;
			issue_write(a, v, 1'b0);
			wait_idle();
		end
		for (int n = 0; n < NUM_RAND; n++)
			check_reg_read(addrs[n]);

		// untouched register keeps its seeded value
		do
			a = 8'($random(seed));
		while (touched[a]);
		check_reg_read(a);

		// unmapped offsets flag pslverr inside the APB tasks
		apb_read(8'h24, d);
		apb_write(8'h40, 32'h0000_00a5);

		// auto capture on one data-ready edge
		apb_write(OFS_CTRL, 32'h0000_0004);
		pulse_drdy();
		wait_status(2, 1'b1);
		check_sample();

		// edge arrives while a write to a burst register runs
		k = int'({$random(seed)} % 32'(BURST_BYTES));
		a = REG_TEMP2 + 8'(k);
		v = 8'($random(seed));
		issue_write(a, v, 1'b1);
		apb_read(OFS_STATUS, d);
		check_flag("STATUS busy before data-ready edge", 1'b1, d[0]);
		pulse_drdy();
		wait_status(2, 1'b1);
		wait_idle();
		check_sample();

		// no sensor on the bus
		apb_write(OFS_CTRL, 32'h0000_0000);
		@(posedge clk);
		absent <= 1'b1;
		a = 8'($random(seed));
		v = ~exp_mem[a];
		issue_write(a, v, 1'b0);
		wait_idle();
		apb_read(OFS_STATUS, d);
		check_flag("STATUS nack with sensor absent", 1'b1, d[1]);
		@(posedge clk);
		absent <= 1'b0;
		apb_write(OFS_CTRL, 32'h0000_0000);
		apb_read(OFS_STATUS, d);
		check_flag("STATUS nack after CTRL write", 1'b0, d[1]);
		check_reg_read(a);

		$display("test passed");
		$finish;
	end

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic o_clk,
	output logic o_rst_n
);
	localparam int HALF_NS = 2;
	localparam int RESET_CYCLES = 3;

	initial begin
		o_clk = 1'b0;
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		o_rst_n <= 1'b1;
	end

	always #(HALF_NS) o_clk = ~o_clk;

endmodule

/* src/adxl_apb_top.sv */
`timescale 1ns/1ps

module adxl_apb_top (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  logic                i_psel,
	input  logic                i_penable,
	input  logic                i_pwrite,
	input  adxl_pkg::apb_addr_t i_paddr,
	input  logic [31:0]         i_pwdata,
	input  logic                i_drdy,
	input  logic                i_sda,
	output logic [31:0]         o_prdata,
	output logic                o_pready,
	output logic                o_pslverr,
	output logic                o_scl_low,
	output logic                o_sda_low
);
	import i2c_pkg::*;
	import adxl_pkg::*;

	// register block to sequencer
	logic req_valid;
	xfer_kind_e req_kind;
	reg_addr_t req_reg;
	byte_t req_data;
	logic busy;
	logic nack_evt;
	byte_t rd_byte;
	logic rd_strobe;

	// sequencer to byte engine
	logic cmd_valid;
	logic cmd_ready;
	i2c_cmd_e cmd;
	byte_t cmd_byte;
	logic rsp_valid;
	byte_t rsp_byte;
	logic rsp_nack;

	// burst path
	byte_t burst_byte;
	logic burst_strobe;
	logic burst_done;
	logic sample_strobe;
	temp_t temp;
	accel_t accx;
	accel_t accy;
	accel_t accz;

	apb_regs u_regs (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
		.i_paddr(i_paddr), .i_pwdata(i_pwdata),
		.o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
		.i_drdy(i_drdy), .i_busy(busy), .i_nack_evt(nack_evt),
		.i_rd_byte(rd_byte), .i_rd_strobe(rd_strobe), .i_sample_strobe(sample_strobe),
		.i_temp(temp), .i_accx(accx), .i_accy(accy), .i_accz(accz),
		.o_req_valid(req_valid), .o_req_kind(req_kind),
		.o_req_reg(req_reg), .o_req_data(req_data)
	);

	xfer_sequencer u_seq (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_req_valid(req_valid), .i_req_kind(req_kind),
		.i_req_reg(req_reg), .i_req_data(req_data),
		.i_cmd_ready(cmd_ready), .i_rsp_valid(rsp_valid),
		.i_rsp_byte(rsp_byte), .i_rsp_nack(rsp_nack),
		.o_busy(busy), .o_cmd_valid(cmd_valid), .o_cmd(cmd), .o_cmd_byte(cmd_byte),
		.o_rd_byte(rd_byte), .o_rd_strobe(rd_strobe), .o_nack_evt(nack_evt),
		.o_burst_byte(burst_byte), .o_burst_strobe(burst_strobe),
		.o_burst_done(burst_done)
	);

	i2c_byte_engine u_engine (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_cmd_valid(cmd_valid), .i_cmd(cmd), .i_cmd_byte(cmd_byte), .i_sda(i_sda),
		.o_cmd_ready(cmd_ready), .o_rsp_valid(rsp_valid),
		.o_rsp_byte(rsp_byte), .o_rsp_nack(rsp_nack),
		.o_scl_low(o_scl_low), .o_sda_low(o_sda_low)
	);

	sample_unpack u_unpack (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_burst_byte(burst_byte), .i_burst_strobe(burst_strobe),
		.i_burst_done(burst_done), .o_sample_strobe(sample_strobe),
		.o_temp(temp), .o_accx(accx), .o_accy(accy), .o_accz(accz)
	);

endmodule

/* src/adxl_pkg.sv */
package adxl_pkg;

	// burst starts at TEMP2 and runs through ZDATA1
	localparam logic [7:0] REG_TEMP2 = 8'h06;
	localparam int BURST_BYTES = 11;

	typedef logic [7:0] reg_addr_t;
	typedef logic [31:0] temp_t;
	typedef logic signed [31:0] accel_t;
	typedef logic [7:0] apb_addr_t;

	// apb byte offsets
	localparam apb_addr_t OFS_CTRL = 8'h00;
	localparam apb_addr_t OFS_REG_ADDR = 8'h04;
	localparam apb_addr_t OFS_WR_DATA = 8'h08;
	localparam apb_addr_t OFS_STATUS = 8'h0C;
	localparam apb_addr_t OFS_RD_DATA = 8'h10;
	localparam apb_addr_t OFS_TEMP = 8'h14;
	localparam apb_addr_t OFS_ACCX = 8'h18;
	localparam apb_addr_t OFS_ACCY = 8'h1C;
	localparam apb_addr_t OFS_ACCZ = 8'h20;

	// request types from the register block
	typedef enum logic [1:0] {
		XFER_WRITE,
		XFER_READ,
		XFER_BURST
	} xfer_kind_e;

endpackage

/* src/apb_regs.sv */
`timescale 1ns/1ps

module apb_regs (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_psel,
	input  logic                 i_penable,
	input  logic                 i_pwrite,
	input  adxl_pkg::apb_addr_t  i_paddr,
	input  logic [31:0]          i_pwdata,
	output logic [31:0]          o_prdata,
	output logic                 o_pready,
	output logic                 o_pslverr,
	input  logic                 i_drdy,
	input  logic                 i_busy,
	input  logic                 i_nack_evt,
	input  i2c_pkg::byte_t       i_rd_byte,
	input  logic                 i_rd_strobe,
	input  logic                 i_sample_strobe,
	input  adxl_pkg::temp_t      i_temp,
	input  adxl_pkg::accel_t     i_accx,
	input  adxl_pkg::accel_t     i_accy,
	input  adxl_pkg::accel_t     i_accz,
	output logic                 o_req_valid,
	output adxl_pkg::xfer_kind_e o_req_kind,
	output adxl_pkg::reg_addr_t  o_req_reg,
	output i2c_pkg::byte_t       o_req_data
);
	import i2c_pkg::*;
	import adxl_pkg::*;

	logic wr_en;
	logic rd_en;
	logic go_wr;
	logic can_issue;
	logic mapped;
	logic ctrl_rd;
	logic auto_en;
	logic nack_q;
	logic valid_q;
	logic pending;
	reg_addr_t reg_addr_q;
	byte_t wr_data_q;
	byte_t rd_data_q;
	logic drdy_meta;
	logic drdy_sync;
	logic drdy_prev;

	assign wr_en = i_psel & i_penable & i_pwrite;
	assign rd_en = i_psel & i_penable & ~i_pwrite;
	assign go_wr = wr_en && (i_paddr == OFS_CTRL) && i_pwdata[0];
	// one request in flight at a time
	assign can_issue = !i_busy && !o_req_valid;
	assign o_pready = 1'b1;
	assign o_pslverr = i_psel & i_penable & ~mapped;

	always_comb begin
		mapped = 1'b1;
		case (i_paddr)
			OFS_CTRL: o_prdata = {29'b0, auto_en, ctrl_rd, 1'b0};
			OFS_REG_ADDR: o_prdata = {24'b0, reg_addr_q};
			OFS_WR_DATA: o_prdata = {24'b0, wr_data_q};
			OFS_STATUS: o_prdata = {29'b0, valid_q, nack_q, i_busy | o_req_valid};
			OFS_RD_DATA: o_prdata = {24'b0, rd_data_q};
			OFS_TEMP: o_prdata = i_temp;
			OFS_ACCX: o_prdata = i_accx;
			OFS_ACCY: o_prdata = i_accy;
			OFS_ACCZ: o_prdata = i_accz;
			default: begin
				o_prdata = 32'b0;
				mapped = 1'b0;
			end
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ctrl_rd <= 1'b0;
			auto_en <= 1'b0;
			nack_q <= 1'b0;
			valid_q <= 1'b0;
			pending <= 1'b0;
			reg_addr_q <= '0;
			wr_data_q <= '0;
			rd_data_q <= '0;
			drdy_meta <= 1'b0;
			drdy_sync <= 1'b0;
			drdy_prev <= 1'b0;
			o_req_valid <= 1'b0;
			o_req_kind <= XFER_WRITE;
			o_req_reg <= '0;
			o_req_data <= '0;
		end else begin
			// data-ready comes from outside, synchronize first
			drdy_meta <= i_drdy;
			drdy_sync <= drdy_meta;
			drdy_prev <= drdy_sync;
			o_req_valid <= 1'b0;

			if (wr_en) begin
				case (i_paddr)
					OFS_CTRL: begin
						ctrl_rd <= i_pwdata[1];
						auto_en <= i_pwdata[2];
						nack_q <= 1'b0;
					end
					OFS_REG_ADDR: reg_addr_q <= i_pwdata[7:0];
					OFS_WR_DATA: wr_data_q <= i_pwdata[7:0];
					default: ;
				endcase
			end

			if (rd_en && i_paddr == OFS_TEMP) valid_q <= 1'b0;
			if (i_sample_strobe) valid_q <= 1'b1;
			if (i_nack_evt) nack_q <= 1'b1;
			if (i_rd_strobe) rd_data_q <= i_rd_byte;

			// host request first, held burst when the path is free
			if (go_wr && can_issue) begin
				o_req_valid <= 1'b1;
				o_req_kind <= i_pwdata[1] ? XFER_READ : XFER_WRITE;
				o_req_reg <= reg_addr_q;
				o_req_data <= wr_data_q;
			end else if (pending && can_issue) begin
				o_req_valid <= 1'b1;
				o_req_kind <= XFER_BURST;
				o_req_reg <= REG_TEMP2;
				o_req_data <= '0;
				pending <= 1'b0;
			end

			// a fresh edge wins over the clear above
			if (drdy_sync && !drdy_prev && auto_en) pending <= 1'b1;
		end
	end

endmodule

/* src/i2c_byte_engine.sv */
`timescale 1ns/1ps

module i2c_byte_engine (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  logic              i_cmd_valid,
	input  i2c_pkg::i2c_cmd_e i_cmd,
	input  i2c_pkg::byte_t    i_cmd_byte,
	input  logic              i_sda,
	output logic              o_cmd_ready,
	output logic              o_rsp_valid,
	output i2c_pkg::byte_t    o_rsp_byte,
	output logic              o_rsp_nack,
	output logic              o_scl_low,
	output logic              o_sda_low
);
	import i2c_pkg::*;

	localparam int QW = (QUARTER_CYCLES > 1) ? $clog2(QUARTER_CYCLES) : 1;

	typedef enum logic [1:0] {
		ENG_IDLE,
		ENG_START,
		ENG_STOP,
		ENG_BIT
	} eng_state_e;

	eng_state_e state;
	logic [QW-1:0] qcnt;
	logic [1:0] phase;
	logic [3:0] bit_idx;
	logic is_read;
	logic send_nack;
	byte_t sreg;
	logic sda_smp;
	logic q_end;
	logic unit_end;
	logic scl_dec;
	logic sda_dec;

	assign q_end = (qcnt == QW'(QUARTER_CYCLES - 1));
	assign unit_end = q_end && (phase == 2'd3);
	assign o_cmd_ready = (state == ENG_IDLE);
	assign o_rsp_byte = sreg;

	// line pattern per quarter phase
	always_comb begin
		scl_dec = 1'b0;
		sda_dec = 1'b0;
		case (state)
			ENG_START: begin
				// bus is free here, sda falls while scl is high
				sda_dec = (phase >= 2'd2);
				scl_dec = (phase == 2'd3);
			end
			ENG_STOP: begin
				scl_dec = (phase == 2'd0);
				sda_dec = (phase != 2'd3);
			end
			ENG_BIT: begin
				// scl high in phases 1 and 2
				scl_dec = (phase == 2'd0) || (phase == 2'd3);
				if (bit_idx == 4'd8) sda_dec = is_read && !send_nack;
				else sda_dec = !is_read && !sreg[7];
			end
			default: ;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= ENG_IDLE;
			qcnt <= '0;
			phase <= 2'd0;
			bit_idx <= 4'd0;
			is_read <= 1'b0;
			send_nack <= 1'b0;
			o_rsp_valid <= 1'b0;
			o_rsp_nack <= 1'b0;
			o_scl_low <= 1'b0;
			o_sda_low <= 1'b0;
		end else begin
			o_rsp_valid <= 1'b0;
			// lines hold their level between commands
			if (state != ENG_IDLE) begin
				o_scl_low <= scl_dec;
				o_sda_low <= sda_dec;
			end

			if (state == ENG_IDLE) begin
				qcnt <= '0;
				phase <= 2'd0;
				bit_idx <= 4'd0;
				if (i_cmd_valid) begin
					case (i_cmd)
						CMD_START: state <= ENG_START;
						CMD_STOP: state <= ENG_STOP;
						default: state <= ENG_BIT;
					endcase
					is_read <= (i_cmd == CMD_READ_ACK) || (i_cmd == CMD_READ_NACK);
					send_nack <= (i_cmd == CMD_READ_NACK);
				end
			end else begin
				qcnt <= q_end ? '0 : qcnt + 1'b1;
				if (q_end) phase <= phase + 2'd1;
				if (unit_end) begin
					if (state == ENG_BIT && bit_idx != 4'd8) begin
						bit_idx <= bit_idx + 4'd1;
					end else begin
						state <= ENG_IDLE;
						o_rsp_valid <= 1'b1;
						// ack slot of a write, sampled from the slave
						o_rsp_nack <= (state == ENG_BIT) && !is_read && sda_smp;
					end
				end
			end
		end
	end

	// msb first; reads shift the sampled line in
	always_ff @(posedge i_clk) begin
		if (state == ENG_IDLE && i_cmd_valid) begin
			sreg <= (i_cmd == CMD_WRITE) ? i_cmd_byte : 8'hFF;
		end else if (state == ENG_BIT) begin
			if (q_end && phase == 2'd1) sda_smp <= i_sda;
			if (unit_end && bit_idx != 4'd8) sreg <= {sreg[6:0], sda_smp};
		end
	end

endmodule

/* src/i2c_pkg.sv */
package i2c_pkg;

	// i_clk cycles per quarter of an SCL period
	localparam int QUARTER_CYCLES = 4;

	// fixed 7-bit sensor address
	localparam logic [6:0] DEV_ADDR = 7'h1D;

	typedef logic [7:0] byte_t;

	// byte engine operations
	typedef enum logic [2:0] {
		CMD_START,
		CMD_STOP,
		CMD_WRITE,
		CMD_READ_ACK,
		CMD_READ_NACK
	} i2c_cmd_e;

endpackage

/* src/sample_unpack.sv */
`timescale 1ns/1ps

module sample_unpack (
	input  logic             i_clk,
	input  logic             i_rst_n,
	input  i2c_pkg::byte_t   i_burst_byte,
	input  logic             i_burst_strobe,
	input  logic             i_burst_done,
	output logic             o_sample_strobe,
	output adxl_pkg::temp_t  o_temp,
	output adxl_pkg::accel_t o_accx,
	output adxl_pkg::accel_t o_accy,
	output adxl_pkg::accel_t o_accz
);
	import i2c_pkg::*;
	import adxl_pkg::*;

	byte_t byte_buf [BURST_BYTES];
	logic [3:0] idx;
	logic full;

	// 20-bit axis value, sign extended
	function automatic accel_t axis(input byte_t hi, input byte_t mid, input byte_t lo);
		return accel_t'({{12{hi[7]}}, hi, mid, lo[7:4]});
	endfunction

	assign full = (idx == 4'(BURST_BYTES));

	always_ff @(posedge i_clk) begin
		if (i_burst_strobe && !full) byte_buf[idx] <= i_burst_byte;
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			idx <= 4'd0;
			o_sample_strobe <= 1'b0;
			o_temp <= '0;
			o_accx <= '0;
			o_accy <= '0;
			o_accz <= '0;
		end else begin
			o_sample_strobe <= 1'b0;
			if (i_burst_done) begin
				idx <= 4'd0;
				// an aborted burst leaves the old sample in place
				if (full) begin
					o_sample_strobe <= 1'b1;
					o_temp <= {20'b0, byte_buf[0][3:0], byte_buf[1]};
					o_accx <= axis(byte_buf[2], byte_buf[3], byte_buf[4]);
					o_accy <= axis(byte_buf[5], byte_buf[6], byte_buf[7]);
					o_accz <= axis(byte_buf[8], byte_buf[9], byte_buf[10]);
				end
			end else if (i_burst_strobe && !full) begin
				idx <= idx + 4'd1;
			end
		end
	end

endmodule

/* src/xfer_sequencer.sv */
`timescale 1ns/1ps

module xfer_sequencer (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_req_valid,
	input  adxl_pkg::xfer_kind_e i_req_kind,
	input  adxl_pkg::reg_addr_t  i_req_reg,
	input  i2c_pkg::byte_t       i_req_data,
	input  logic                 i_cmd_ready,
	input  logic                 i_rsp_valid,
	input  i2c_pkg::byte_t       i_rsp_byte,
	input  logic                 i_rsp_nack,
	output logic                 o_busy,
	output logic                 o_cmd_valid,
	output i2c_pkg::i2c_cmd_e    o_cmd,
	output i2c_pkg::byte_t       o_cmd_byte,
	output i2c_pkg::byte_t       o_rd_byte,
	output logic                 o_rd_strobe,
	output logic                 o_nack_evt,
	output i2c_pkg::byte_t       o_burst_byte,
	output logic                 o_burst_strobe,
	output logic                 o_burst_done
);
	import i2c_pkg::*;
	import adxl_pkg::*;

	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_START,
		SEQ_ADDR,
		SEQ_REG,
		SEQ_DATA,
		SEQ_READ,
		SEQ_STOP
	} seq_state_e;

	seq_state_e state;
	xfer_kind_e kind;
	reg_addr_t reg_q;
	byte_t data_q;
	byte_t rx_byte;
	logic cmd_sent;
	logic rd_phase;
	logic aborted;
	logic [3:0] rd_cnt;

	assign o_busy = (state != SEQ_IDLE);
	assign o_cmd_valid = (state != SEQ_IDLE) && !cmd_sent;
	assign o_rd_byte = rx_byte;
	assign o_burst_byte = rx_byte;

	always_comb begin
		o_cmd_byte = 8'h00;
		case (state)
			SEQ_START: o_cmd = CMD_START;
			SEQ_ADDR: begin
				o_cmd = CMD_WRITE;
				o_cmd_byte = {DEV_ADDR, rd_phase};
			end
			SEQ_REG: begin
				o_cmd = CMD_WRITE;
				o_cmd_byte = reg_q;
			end
			SEQ_DATA: begin
				o_cmd = CMD_WRITE;
				o_cmd_byte = data_q;
			end
			// the last byte of a read gets a NACK
			SEQ_READ: o_cmd = (rd_cnt == 4'd0) ? CMD_READ_NACK : CMD_READ_ACK;
			default: o_cmd = CMD_STOP;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= SEQ_IDLE;
			kind <= XFER_WRITE;
			cmd_sent <= 1'b0;
			rd_phase <= 1'b0;
			aborted <= 1'b0;
			rd_cnt <= 4'd0;
			o_rd_strobe <= 1'b0;
			o_burst_strobe <= 1'b0;
			o_nack_evt <= 1'b0;
			o_burst_done <= 1'b0;
		end else begin
			o_rd_strobe <= 1'b0;
			o_burst_strobe <= 1'b0;
			o_nack_evt <= 1'b0;
			o_burst_done <= 1'b0;
			if (o_cmd_valid && i_cmd_ready) cmd_sent <= 1'b1;

			if (state == SEQ_IDLE) begin
				if (i_req_valid) begin
					kind <= i_req_kind;
					rd_phase <= 1'b0;
					aborted <= 1'b0;
					state <= SEQ_START;
				end
			end else if (i_rsp_valid) begin
				cmd_sent <= 1'b0;
				case (state)
					SEQ_START: state <= SEQ_ADDR;
					SEQ_ADDR, SEQ_REG: begin
						if (i_rsp_nack) begin
							o_nack_evt <= 1'b1;
							aborted <= 1'b1;
							state <= SEQ_STOP;
						end else if (state == SEQ_REG) begin
							state <= (kind == XFER_WRITE) ? SEQ_DATA : SEQ_STOP;
						end else if (rd_phase) begin
							rd_cnt <= (kind == XFER_BURST) ? 4'(BURST_BYTES - 1) : 4'd0;
							state <= SEQ_READ;
						end else begin
							state <= SEQ_REG;
						end
					end
					SEQ_DATA: begin
						o_nack_evt <= i_rsp_nack;
						aborted <= i_rsp_nack;
						state <= SEQ_STOP;
					end
					SEQ_READ: begin
						if (kind == XFER_BURST) o_burst_strobe <= 1'b1;
						else o_rd_strobe <= 1'b1;
						if (rd_cnt == 4'd0) state <= SEQ_STOP;
						else rd_cnt <= rd_cnt - 4'd1;
					end
					SEQ_STOP: begin
						// pointer write done, now the separate read transaction
						if (!aborted && kind != XFER_WRITE && !rd_phase) begin
							rd_phase <= 1'b1;
							state <= SEQ_START;
						end else begin
							o_burst_done <= (kind == XFER_BURST);
							state <= SEQ_IDLE;
						end
					end
					default: state <= SEQ_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == SEQ_IDLE && i_req_valid) begin
			reg_q <= i_req_reg;
			data_q <= i_req_data;
		end
		if (i_rsp_valid && state == SEQ_READ) rx_byte <= i_rsp_byte;
	end

endmodule
